// ==== verilog.f ====
+incdir+tests
logic/swarm_pkg.sv
logic/lowbit.sv
logic/task_queue.sv
logic/conflict_serializer.sv
logic/task_unit.sv
tests/tb_task_unit.sv

// ==== Bender.yml ====
package:
  name: task_unit

sources:
  - logic/swarm_pkg.sv
  - logic/lowbit.sv
  - logic/task_queue.sv
  - logic/conflict_serializer.sv
  - logic/task_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_task_unit.sv

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// hint each core runs according to the model
hint_t                run_hint [NUM_CORES];
logic [NUM_CORES-1:0] run_valid;

// one pending task and the slot tag it must come back with
typedef struct packed {
   cq_slice_slot_t slot;
   task_t          t;
} pending_t;

// tasks per hint in enqueue order
pending_t pending [256][$];
int       enq_count;
int       srv_count;

// serving hint h to core c is legal when no other core runs h
function automatic bit hint_free(input int c, input hint_t h);
   for (int k = 0; k < NUM_CORES; k++) begin
      if ((k != c) && run_valid[k] && (run_hint[k] == h)) begin
         return 1'b0;
      end
   end
   return 1'b1;
endfunction

// a wildcard request takes any type at or below TYPE_ANY
function automatic bit type_matches(input task_type_t req, input task_type_t got);
   if (req == TYPE_ANY) begin
      return got <= TYPE_ANY;
   end
   return got == req;
endfunction

// next task expected for hint h, the oldest one still pending
function automatic pending_t expected_serve(input hint_t h);
   return pending[h][0];
endfunction

// core 0 is not part of the idle report
function automatic bit cores_idle_model();
   return run_valid[NUM_CORES-1:1] == '0;
endfunction

task automatic record_enqueue(input task_t t);
   pending_t p;
   p.slot = cq_slice_slot_t'(enq_count);
   p.t    = t;
   pending[t.hint].push_back(p);
   enq_count++;
endtask

task automatic record_serve(input int c, input hint_t h);
   if (pending[h].size() != 0) begin
      void'(pending[h].pop_front());
   end
   run_hint[c]  = h;
   run_valid[c] = 1'b1;
   srv_count++;
endtask

`endif

// ==== tests/tb_task_unit.sv ====
`timescale 1ns/1ps

module tb_task_unit
   import swarm_pkg::*;
();

   localparam int NUM_CORES           = 4;
   localparam int LOG_READY_LIST_SIZE = 3;
   localparam int QUEUE_DEPTH         = 16;
   localparam int CLK_PERIOD          = 4;
   localparam int N_RANDOM            = 60;
   localparam int FLOOD               = QUEUE_DEPTH + 2 ** LOG_READY_LIST_SIZE;
   localparam int MAX_HOLD            = 8;
   localparam int MARGIN              = 6;
   localparam int WATCHDOG_NS = (N_RANDOM + FLOOD + 1) * MAX_HOLD * MARGIN * CLK_PERIOD + 5000;

   logic                       clk;
   logic                       rstn;
   logic                       enq_valid;
   task_t                      enq_task;
   logic                       enq_ready;
   logic       [NUM_CORES-1:0] s_arvalid;
   task_type_t [NUM_CORES-1:0] s_araddr;
   logic       [NUM_CORES-1:0] s_rvalid;
   task_t                      s_rdata;
   cq_slice_slot_t             s_cq_slot;
   logic                       finished_task_valid;
   core_id_t                   finished_task_core;
   logic                       almost_full;
   logic                       all_cores_idle;

   integer               seed = 13539;
   int                   errors;
   int                   checks;
   int                   tests_run;
   int                   err_mark;
   bit                   checking;
   bit                   cores_on;
   bit                   hold_forever;
   bit   [NUM_CORES-1:0] busy;
   int                   hold [NUM_CORES];
   logic [NUM_CORES-1:0] prev_rvalid;

   `include "tb_ref_model.svh"

   task_unit #(
      .NUM_CORES           (NUM_CORES),
      .LOG_READY_LIST_SIZE (LOG_READY_LIST_SIZE),
      .QUEUE_DEPTH         (QUEUE_DEPTH)
   ) dut0 (
      .clk                 (clk),
      .rstn                (rstn),
      .enq_valid           (enq_valid),
      .enq_task            (enq_task),
      .enq_ready           (enq_ready),
      .s_arvalid           (s_arvalid),
      .s_araddr            (s_araddr),
      .s_rvalid            (s_rvalid),
      .s_rdata             (s_rdata),
      .s_cq_slot           (s_cq_slot),
      .finished_task_valid (finished_task_valid),
      .finished_task_core  (finished_task_core),
      .almost_full         (almost_full),
      .all_cores_idle      (all_cores_idle)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return {$random(seed)} % n;
   endfunction

   task automatic report_value(input string sig, input logic [31:0] got,
                               input logic [31:0] exp);
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
      errors++;
   endtask

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic finish_test(input string name);
      $display("test %-16s done, %0d errors", name, errors - err_mark);
      err_mark = errors;
      tests_run++;
   endtask

   function automatic task_t make_task(input hint_t h);
      task_t t;
      t.ttype   = task_type_t'(rand_below(N_TASK_TYPES));
      t.hint    = h;
      // payload doubles as a sequence number
      t.payload = 16'(enq_count);
      return t;
   endfunction

   // enq_ready only moves after a rising edge, so it holds for the next one
   task automatic push_task(input task_t t);
      @(negedge clk);
      while (!enq_ready) begin
         enq_valid <= 1'b0;
         @(negedge clk);
      end
      enq_valid <= 1'b1;
      enq_task  <= t;
      record_enqueue(t);
   endtask

   task automatic stop_push();
      @(negedge clk);
      enq_valid <= 1'b0;
   endtask

   task automatic wait_drained();
      while ((srv_count != enq_count) || (run_valid != '0)) begin
         @(negedge clk);
      end
   endtask

   task automatic check_drained();
      @(negedge clk);
      checks += 3;
      assert (all_cores_idle) else report_value("all_cores_idle", all_cores_idle, 1);
      assert (enq_ready) else report_value("enq_ready", enq_ready, 1);
      assert (!almost_full) else report_value("almost_full", almost_full, 0);
      for (int h = 0; h < 256; h++) begin
         assert (pending[h].size() == 0)
            else report_error($sformatf("%0d tasks of hint %0d never served",
                                        pending[h].size(), h));
      end
   endtask

   // core models request a task, hold it, then report it finished
   always @(negedge clk) begin : core_models
      bit finish_sent;
      finish_sent = 1'b0;
      finished_task_valid <= 1'b0;
      if (cores_on) begin
         for (int i = 0; i < NUM_CORES; i++) begin
            if (s_rvalid[i]) begin
               busy[i] = 1'b1;
               hold[i] = 1 + rand_below(MAX_HOLD);
            end else if (busy[i]) begin
               // the request stays up over the edge that ends the response
               s_arvalid[i] <= 1'b0;
               if (hold[i] > 0) begin
                  if (!hold_forever) begin
                     hold[i]--;
                  end
               end else if (!finish_sent) begin
                  // one finish report per cycle
                  finished_task_valid <= 1'b1;
                  finished_task_core  <= core_id_t'(i);
                  busy[i] = 1'b0;
                  finish_sent = 1'b1;
               end
            end else if (!s_arvalid[i] && (rand_below(2) == 0)) begin
               // core 0 takes anything so no type is left without a taker
               s_araddr[i]  <= (i == 0) ? TYPE_ANY : task_type_t'(rand_below(N_TASK_TYPES));
               s_arvalid[i] <= 1'b1;
            end
         end
      end
   end

   // the DUT drops the hint on the same edge
   always @(posedge clk) begin
      if (rstn && finished_task_valid) begin
         run_valid[finished_task_core] = 1'b0;
      end
   end

   always @(negedge clk) begin : compare
      pending_t exp;
      if (checking) begin
         checks += 3;
         assert (all_cores_idle == cores_idle_model())
            else report_value("all_cores_idle", all_cores_idle, cores_idle_model());
         assert ($countones(s_rvalid) <= 1)
            else report_error($sformatf("several cores answered, s_rvalid=%b", s_rvalid));
         assert ((s_rvalid & prev_rvalid) == '0)
            else report_error("one core answered in two cycles in a row");
         for (int i = 0; i < NUM_CORES; i++) begin
            if (s_rvalid[i]) begin
               checks += 4;
               assert (s_arvalid[i])
                  else report_error($sformatf("core %0d answered without a request", i));
               assert (hint_free(i, s_rdata.hint))
                  else report_error($sformatf("hint %0d served to core %0d while running elsewhere",
                                              s_rdata.hint, i));
               assert (type_matches(s_araddr[i], s_rdata.ttype))
                  else report_value("s_rdata.ttype", s_rdata.ttype, s_araddr[i]);
               assert (pending[s_rdata.hint].size() != 0)
                  else report_error($sformatf("hint %0d served with no such task pending",
                                              s_rdata.hint));
               if (pending[s_rdata.hint].size() != 0) begin
                  exp = expected_serve(s_rdata.hint);
                  checks += 2;
                  assert (s_rdata == exp.t) else report_value("s_rdata", s_rdata, exp.t);
                  assert (s_cq_slot == exp.slot) else report_value("s_cq_slot", s_cq_slot, exp.slot);
               end
               record_serve(i, s_rdata.hint);
            end
         end
      end
      prev_rvalid = s_rvalid;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog: tests did not complete within %0d ns", WATCHDOG_NS);
      $display("Something failed");
      $finish;
   end

   initial begin
      rstn                = 1'b0;
      enq_valid           = 1'b0;
      enq_task            = '0;
      s_arvalid           = '0;
      finished_task_valid = 1'b0;
      finished_task_core  = '0;
      for (int i = 0; i < NUM_CORES; i++) begin
         s_araddr[i] = TYPE_A;
      end
      run_valid = '0;
      busy      = '0;

      repeat (5) @(posedge clk);
      @(negedge clk);
      checks += 4;
      assert (s_rvalid == '0) else report_value("s_rvalid", s_rvalid, 0);
      assert (!almost_full) else report_value("almost_full", almost_full, 0);
      assert (enq_ready) else report_value("enq_ready", enq_ready, 1);
      assert (all_cores_idle) else report_value("all_cores_idle", all_cores_idle, 1);
      rstn <= 1'b1;
      @(posedge clk);
      checking = 1'b1;
      cores_on = 1'b1;
      finish_test("reset values");

      // few hints so that conflicts are common
      for (int n = 0; n < N_RANDOM; n++) begin
         push_task(make_task(hint_t'(rand_below(6))));
         if (rand_below(4) == 0) begin
            stop_push();
         end
      end
      stop_push();
      wait_drained();
      check_drained();
      finish_test("random traffic");

      // one task holds hint 200, every later task waits on it
      @(posedge clk);
      hold_forever = 1'b1;
      push_task(make_task(8'd200));
      stop_push();
      while (hint_free(-1, 8'd200)) begin
         @(negedge clk);
      end
      for (int n = 0; n < FLOOD; n++) begin
         push_task(make_task(8'd200));
      end
      stop_push();
      for (int w = 0; (w < 64) && enq_ready; w++) begin
         @(negedge clk);
      end
      checks += 3;
      assert (!enq_ready) else report_error("enq_ready never dropped under back-pressure");
      assert (almost_full) else report_value("almost_full", almost_full, 1);
      assert (enq_count - srv_count == FLOOD)
         else report_value("waiting tasks", enq_count - srv_count, FLOOD);
      finish_test("back-pressure");

      @(posedge clk);
      hold_forever = 1'b0;
      wait_drained();
      check_drained();
      finish_test("release and drain");

      $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== logic/task_unit.sv ====
`timescale 1ns/1ps

// task dispatch unit: queue in front of the conflict serializer
module task_unit
   import swarm_pkg::*;
#(
   parameter int NUM_CORES           = 4,
   parameter int LOG_READY_LIST_SIZE = 3,
   parameter int QUEUE_DEPTH         = 16
) (
   input  logic                       clk,
   input  logic                       rstn,

   // host enqueue
   input  logic                       enq_valid,
   input  task_t                      enq_task,
   output logic                       enq_ready,

   // cores
   input  logic       [NUM_CORES-1:0] s_arvalid,
   input  task_type_t [NUM_CORES-1:0] s_araddr,
   output logic       [NUM_CORES-1:0] s_rvalid,
   output task_t                      s_rdata,
   output cq_slice_slot_t             s_cq_slot,

   // finish reports
   input  logic                       finished_task_valid,
   input  core_id_t                   finished_task_core,

   output logic                       almost_full,
   output logic                       all_cores_idle
);

   // queue head toward the serializer
   logic           m_valid;
   task_t          m_task;
   cq_slice_slot_t m_cq_slot;
   logic           m_ready;

   task_queue #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) queue0 (
      .clk       (clk),
      .rstn      (rstn),
      .enq_valid (enq_valid),
      .enq_task  (enq_task),
      .enq_ready (enq_ready),
      .m_valid   (m_valid),
      .m_task    (m_task),
      .m_cq_slot (m_cq_slot),
      .m_ready   (m_ready)
   );

   conflict_serializer #(
      .NUM_CORES           (NUM_CORES),
      .LOG_READY_LIST_SIZE (LOG_READY_LIST_SIZE)
   ) serializer0 (
      .clk                 (clk),
      .rstn                (rstn),
      .s_arvalid           (s_arvalid),
      .s_araddr            (s_araddr),
      .s_rvalid            (s_rvalid),
      .s_rdata             (s_rdata),
      .s_cq_slot           (s_cq_slot),
      .finished_task_valid (finished_task_valid),
      .finished_task_core  (finished_task_core),
      .m_task              (m_task),
      .m_cq_slot           (m_cq_slot),
      .m_valid             (m_valid),
      .m_ready             (m_ready),
      .almost_full         (almost_full),
      .all_cores_idle      (all_cores_idle)
   );

endmodule

// ==== logic/conflict_serializer.sv ====
`timescale 1ns/1ps

// hands ready tasks to requesting cores while keeping tasks with equal
// hints from running at the same time
//
// the ready list is a compacted shift register; each entry has a valid and
// a conflict bit. a request gets the earliest conflict-free entry of its
// type, and a finish clears the conflict bit of the earliest entry that
// waits on the finished hint
module conflict_serializer
   import swarm_pkg::*;
#(
   parameter int NUM_CORES           = 4,
   parameter int LOG_READY_LIST_SIZE = 3
) (
   input  logic                          clk,
   input  logic                          rstn,

   // core requests, answered by s_rvalid one cycle after selection
   input  logic       [NUM_CORES-1:0]    s_arvalid,
   input  task_type_t [NUM_CORES-1:0]    s_araddr,
   output logic       [NUM_CORES-1:0]    s_rvalid,
   output task_t                         s_rdata,
   output cq_slice_slot_t                s_cq_slot,

   // finish reports
   input  logic                          finished_task_valid,
   input  core_id_t                      finished_task_core,

   // from the task queue
   input  task_t                         m_task,
   input  cq_slice_slot_t                m_cq_slot,
   input  logic                          m_valid,
   output logic                          m_ready,

   output logic                          almost_full,
   output logic                          all_cores_idle
);

   localparam int READY_LIST_SIZE = 2 ** LOG_READY_LIST_SIZE;
   localparam int CORE_W          = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;
   localparam int AF_LEVEL        = READY_LIST_SIZE - 4;

   // ready list storage
   task_t                      ready_list         [READY_LIST_SIZE];
   cq_slice_slot_t             ready_list_cq_slot [READY_LIST_SIZE];
   logic [READY_LIST_SIZE-1:0] ready_list_valid;
   logic [READY_LIST_SIZE-1:0] ready_list_conflict;

   // per-core running hint
   hint_t                      running_task_hint  [NUM_CORES];
   logic [NUM_CORES-1:0]       running_task_hint_valid;

   // stage two registers
   logic                           reg_valid;
   logic [CORE_W-1:0]              reg_core_id;
   logic [LOG_READY_LIST_SIZE-1:0] reg_task_select;

   logic [READY_LIST_SIZE-1:0]     type_ready [N_TASK_TYPES];
   logic [NUM_CORES-1:0]           can_take_request;
   logic [CORE_W-1:0]              core_select;
   logic [READY_LIST_SIZE-1:0]     task_select_in;
   logic [LOG_READY_LIST_SIZE-1:0] task_select;

   hint_t                          finished_hint;
   logic [READY_LIST_SIZE-1:0]     finish_match;
   logic [LOG_READY_LIST_SIZE-1:0] finish_select;
   logic [READY_LIST_SIZE-1:0]     clear_at;

   logic [LOG_READY_LIST_SIZE-1:0] next_insert_location;
   logic                           insert_fire;
   logic [READY_LIST_SIZE-1:0]     insert_hits_ready;
   logic [NUM_CORES-1:0]           insert_hits_running;
   logic                           insert_conflict;
   logic [READY_LIST_SIZE-1:0]     shift_at;
   logic [READY_LIST_SIZE-1:0]     load_at;

   logic [LOG_READY_LIST_SIZE:0]   ready_count;
   logic [LOG_READY_LIST_SIZE:0]   ready_count_next;

   // ready vectors per requested type
   // the entry leaving in stage two is not offered again
   always_comb begin
      for (int t = 0; t < N_TASK_TYPES; t++) begin
         for (int j = 0; j < READY_LIST_SIZE; j++) begin
            type_ready[t][j] = ready_list_valid[j] && !ready_list_conflict[j]
               && ((t == int'(TASK_TYPE_ALL)) ? (ready_list[j].ttype <= TASK_TYPE_ALL)
                                               : (int'(ready_list[j].ttype) == t))
               && !(reg_valid && (int'(reg_task_select) == j));
         end
      end
   end

   // stage one: pick a core, then its earliest matching entry
   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         can_take_request[i] = s_arvalid[i]
            && (type_ready[s_araddr[i]] != '0)
            && !(reg_valid && (int'(reg_core_id) == i));
      end
   end

   lowbit #(
      .IN_WIDTH  (NUM_CORES),
      .OUT_WIDTH (CORE_W)
   ) core_sel (
      .in  (can_take_request),
      .out (core_select)
   );

   assign task_select_in = type_ready[s_araddr[core_select]];

   lowbit #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) task_sel (
      .in  (task_select_in),
      .out (task_select)
   );

   always_ff @(posedge clk) begin
      if (!rstn) begin
         reg_valid       <= 1'b0;
         reg_core_id     <= '0;
         reg_task_select <= '0;
      end else begin
         reg_valid   <= can_take_request[core_select];
         reg_core_id <= core_select;
         // entries above a dequeue move down by one this cycle
         if (reg_valid && (task_select > reg_task_select)) begin
            reg_task_select <= task_select - 1'b1;
         end else begin
            reg_task_select <= task_select;
         end
      end
   end

   // stage two response
   always_comb begin
      for (int i = 0; i < NUM_CORES; i++) begin
         s_rvalid[i] = reg_valid && (int'(reg_core_id) == i);
      end
   end

   assign s_rdata   = ready_list[reg_task_select];
   assign s_cq_slot = ready_list_cq_slot[reg_task_select];

   // finish: find the earliest waiting entry with the finished hint
   always_comb begin
      finished_hint = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (finished_task_core == core_id_t'(c)) begin
            finished_hint = running_task_hint[c];
         end
      end
      for (int j = 0; j < READY_LIST_SIZE; j++) begin
         finish_match[j] = finished_task_valid && ready_list_valid[j]
            && ready_list_conflict[j] && (ready_list[j].hint == finished_hint);
      end
   end

   lowbit #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) finish_sel (
      .in  (finish_match),
      .out (finish_select)
   );

   // insert goes to the first empty slot, the list stays compacted
   lowbit #(
      .IN_WIDTH  (READY_LIST_SIZE),
      .OUT_WIDTH (LOG_READY_LIST_SIZE)
   ) insert_sel (
      .in  (~ready_list_valid),
      .out (next_insert_location)
   );

   assign m_ready     = m_valid && !ready_list_valid[next_insert_location];
   assign insert_fire = m_valid && m_ready;

   // incoming task conflicts with anything waiting or still running
   always_comb begin
      for (int j = 0; j < READY_LIST_SIZE; j++) begin
         insert_hits_ready[j] = ready_list_valid[j] && (ready_list[j].hint == m_task.hint);
      end
      for (int c = 0; c < NUM_CORES; c++) begin
         insert_hits_running[c] = running_task_hint_valid[c]
            && (running_task_hint[c] == m_task.hint)
            && !(finished_task_valid && (finished_task_core == core_id_t'(c)));
      end
   end

   assign insert_conflict = (insert_hits_ready != '0) || (insert_hits_running != '0);

   // per-entry moves for this cycle
   always_comb begin
      for (int j = 0; j < READY_LIST_SIZE; j++) begin
         shift_at[j] = reg_valid && (j >= int'(reg_task_select));
         // during a dequeue the insert lands one slot lower
         if (shift_at[j]) begin
            load_at[j] = insert_fire && (int'(next_insert_location) == j + 1);
         end else begin
            load_at[j] = insert_fire && (int'(next_insert_location) == j);
         end
         clear_at[j] = finish_match[j] && (int'(finish_select) == j);
      end
   end

   // task and tag fields
   always_ff @(posedge clk) begin
      for (int j = 0; j < READY_LIST_SIZE; j++) begin
         if (load_at[j]) begin
            ready_list[j]         <= m_task;
            ready_list_cq_slot[j] <= m_cq_slot;
         end else if (shift_at[j] && (j < READY_LIST_SIZE - 1)) begin
            ready_list[j]         <= ready_list[j+1];
            ready_list_cq_slot[j] <= ready_list_cq_slot[j+1];
         end
      end
   end

   // valid and conflict bits
   always_ff @(posedge clk) begin
      if (!rstn) begin
         ready_list_valid    <= '0;
         ready_list_conflict <= '0;
      end else begin
         for (int j = 0; j < READY_LIST_SIZE; j++) begin
            if (load_at[j]) begin
               ready_list_valid[j]    <= 1'b1;
               ready_list_conflict[j] <= insert_conflict;
            end else if (shift_at[j]) begin
               if (j < READY_LIST_SIZE - 1) begin
                  ready_list_valid[j]    <= ready_list_valid[j+1];
                  ready_list_conflict[j] <= ready_list_conflict[j+1] && !clear_at[j+1];
               end else begin
                  // top slot empties when nothing is shifted in
                  ready_list_valid[j]    <= 1'b0;
                  ready_list_conflict[j] <= 1'b0;
               end
            end else if (clear_at[j]) begin
               ready_list_conflict[j] <= 1'b0;
            end
         end
      end
   end

   // occupancy and registered almost_full
   assign ready_count_next = ready_count + insert_fire - reg_valid;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         ready_count <= '0;
         almost_full <= 1'b0;
      end else begin
         ready_count <= ready_count_next;
         almost_full <= (int'(ready_count_next) >= AF_LEVEL);
      end
   end

   // hint table, a response takes priority over a finish on the same core
   always_ff @(posedge clk) begin
      if (!rstn) begin
         running_task_hint_valid <= '0;
      end else begin
         for (int c = 0; c < NUM_CORES; c++) begin
            if (s_rvalid[c]) begin
               running_task_hint_valid[c] <= 1'b1;
            end else if (finished_task_valid && (finished_task_core == core_id_t'(c))) begin
               running_task_hint_valid[c] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int c = 0; c < NUM_CORES; c++) begin
         if (s_rvalid[c]) begin
            running_task_hint[c] <= s_rdata.hint;
         end
      end
   end

   // core 0 runs the ordered-commit helper and is left out
   assign all_cores_idle = (running_task_hint_valid[NUM_CORES-1:1] == '0);

endmodule

// ==== logic/task_queue.sv ====
`timescale 1ns/1ps

// circular task buffer between the host and the serializer
module task_queue
   import swarm_pkg::*;
#(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic           clk,
   input  logic           rstn,

   // host side
   input  logic           enq_valid,
   input  task_t          enq_task,
   output logic           enq_ready,

   // serializer side
   output logic           m_valid,
   output task_t          m_task,
   output cq_slice_slot_t m_cq_slot,
   input  logic           m_ready
);

   localparam int PTR_W = $clog2(QUEUE_DEPTH);

   task_t            mem [QUEUE_DEPTH];
   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] tail;
   logic [PTR_W:0]   count;
   cq_slice_slot_t   next_slot;
   logic             enq_fire;
   logic             deq_fire;

   assign enq_ready = (count != (PTR_W+1)'(QUEUE_DEPTH));
   assign m_valid   = (count != '0);
   assign m_task    = mem[head];
   assign m_cq_slot = next_slot;

   assign enq_fire = enq_valid && enq_ready;
   assign deq_fire = m_valid && m_ready;

   // storage
   always_ff @(posedge clk) begin
      if (enq_fire) begin
         mem[tail] <= enq_task;
      end
   end

   // pointers wrap on their own since the depth is a power of two
   always_ff @(posedge clk) begin
      if (!rstn) begin
         head      <= '0;
         tail      <= '0;
         count     <= '0;
         next_slot <= '0;
      end else begin
         if (enq_fire) begin
            tail <= tail + 1'b1;
         end
         if (deq_fire) begin
            head      <= head + 1'b1;
            // slot tag handed out as the task leaves
            next_slot <= next_slot + 1'b1;
         end
         case ({enq_fire, deq_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// ==== logic/lowbit.sv ====
`timescale 1ns/1ps

// priority encoder, index of the lowest set bit
// returns zero when the input is all zero
module lowbit #(
   parameter int IN_WIDTH  = 8,
   parameter int OUT_WIDTH = 3
) (
   input  logic [IN_WIDTH-1:0]  in,
   output logic [OUT_WIDTH-1:0] out
);

   always_comb begin
      out = '0;
      // walk downwards so the lowest hit is the last one written
      for (int i = IN_WIDTH - 1; i >= 0; i--) begin
         if (in[i]) begin
            out = OUT_WIDTH'(i);
         end
      end
   end

endmodule

// ==== logic/swarm_pkg.sv ====
package swarm_pkg;

   // conflict key; two tasks with the same hint never run together
   typedef logic [7:0] hint_t;

   // task types known to the cores
   typedef enum logic [1:0] {
      TYPE_A   = 2'd0,
      TYPE_B   = 2'd1,
      TYPE_C   = 2'd2,
      TYPE_ANY = 2'd3
   } task_type_t;

   // number of type codes a core may request
   localparam int N_TASK_TYPES = 4;

   // wildcard request, matches every type at or below it
   localparam task_type_t TASK_TYPE_ALL = TYPE_ANY;

   // one task as seen by the host and the cores (26 bits)
   typedef struct packed {
      task_type_t  ttype;
      hint_t       hint;
      logic [15:0] payload;
   } task_t;

   // commit queue slot carried along with each task as a tag
   typedef logic [3:0] cq_slice_slot_t;

   // core index, room for 16 cores
   typedef logic [3:0] core_id_t;

endpackage
